// ==== src/noc_arbiter_defines.svh ====
//******************************
// noc arbiter defines
// router port count, mesh address width, packet length and
// downstream credit depth.
//******************************

`ifndef NOC_ARBITER_DEFINES_SVH
`define NOC_ARBITER_DEFINES_SVH

// north, south, west, east, local.
`define NOC_PORTS 5

// one mesh coordinate; y sits above x in the address.
`define NOC_COORD_W 4

`define NOC_PKT_FLITS 4 // header flit counted.

`define NOC_CREDITS 4 // downstream buffer depth in flits.

`endif

// ==== src/noc_arbiter_pkg.sv ====
//******************************
// noc arbiter package
// port direction and router address types.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

package noc_arbiter_pkg;

	// next hop, vector index and crossbar select.
	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_e;

	typedef struct packed {
		logic [`NOC_COORD_W-1:0] y; // row.
		logic [`NOC_COORD_W-1:0] x; // column.
	} router_addr_t;

endpackage

`default_nettype wire

// ==== src/yx_route.sv ====
//******************************
// yx route
// dimension ordered next hop, y resolved before x.
//******************************

`default_nettype none

module yx_route (
	input  noc_arbiter_pkg::router_addr_t hdr_addr_i,
	input  noc_arbiter_pkg::router_addr_t router_addr_i,
	output noc_arbiter_pkg::port_e        hop_o
);

	import noc_arbiter_pkg::*;

	logic y_lt;
	logic y_gt;
	logic x_lt;
	logic x_gt;

	assign y_lt = hdr_addr_i.y < router_addr_i.y;
	assign y_gt = hdr_addr_i.y > router_addr_i.y;
	assign x_lt = hdr_addr_i.x < router_addr_i.x;
	assign x_gt = hdr_addr_i.x > router_addr_i.x;

	// rows first, then columns.
	always_comb begin
		if (y_lt) begin
			hop_o = PORT_N;
		end else if (y_gt) begin
			hop_o = PORT_S;
		end else if (x_lt) begin
			hop_o = PORT_W;
		end else if (x_gt) begin
			hop_o = PORT_E;
		end else begin
			hop_o = PORT_L; // arrived.
		end
	end

endmodule

`default_nettype wire

// ==== src/input_port_ctrl.sv ====
//******************************
// input port control
// next hop register and packet tracker for one input,
// request to the chosen output.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

module input_port_ctrl #(
	parameter noc_arbiter_pkg::port_e PORT_ID = noc_arbiter_pkg::PORT_N
) (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          ib_valid_i,
	input  noc_arbiter_pkg::router_addr_t hdr_addr_i,
	input  noc_arbiter_pkg::router_addr_t router_addr_i,
	input  logic                          rd_i,
	output noc_arbiter_pkg::port_e        hop_o,
	output logic                          busy_o,
	output logic [`NOC_PORTS-1:0]         req_o,
	output logic                          last_o
);

	import noc_arbiter_pkg::*;

	localparam int NP    = `NOC_PORTS;
	localparam int CNT_W = $clog2(`NOC_PKT_FLITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`NOC_PKT_FLITS - 1);

	port_e            route_hop;
	port_e            hop_q;
	logic             busy_q;
	logic [CNT_W-1:0] flit_cnt_q;
	logic             hdr_take;

	yx_route yx_route_inst (
		.hdr_addr_i    (hdr_addr_i),
		.router_addr_i (router_addr_i),
		.hop_o         (route_hop)
	);

	// head flit is at the buffer front whenever we are idle.
	assign hdr_take = !busy_q && ib_valid_i;

	assign last_o = busy_q && rd_i && (flit_cnt_q == CNT_LAST);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q     <= 1'b0;
			flit_cnt_q <= '0;
		end else if (hdr_take) begin
			busy_q     <= 1'b1;
			flit_cnt_q <= '0;
		end else if (busy_q && rd_i) begin
			if (last_o) begin
				busy_q     <= 1'b0; // packet drained.
				flit_cnt_q <= '0;
			end else begin
				flit_cnt_q <= flit_cnt_q + 1'b1;
			end
		end
	end

	// next hop register, held for the whole packet.
	always_ff @(posedge clk) begin
		if (hdr_take) begin
			hop_q <= route_hop;
		end
	end

	assign hop_o  = hop_q;
	assign busy_o = busy_q;
	assign req_o  = busy_q ? (NP'(1) << hop_q) : '0; // one-hot over outputs.

	// a legal header never turns back to the side it came from.
	a_no_u_turn: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		busy_q |-> (hop_q != PORT_ID)
	) else $error("input %0d routed back to its own side", PORT_ID);

endmodule

`default_nettype wire

// ==== src/rr_arbiter.sv ====
//******************************
// round-robin arbiter
// one per output, locked to the winner for a whole packet.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

module rr_arbiter #(
	parameter noc_arbiter_pkg::port_e PORT_ID = noc_arbiter_pkg::PORT_N
) (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic [`NOC_PORTS-1:0] req_i,
	input  logic [`NOC_PORTS-1:0] last_i,
	output logic [`NOC_PORTS-1:0] grant_o,
	output logic                  locked_o
);

	import noc_arbiter_pkg::*;

	localparam int NP = `NOC_PORTS;
	localparam logic [NP-1:0] OWN_BIT = NP'(1) << PORT_ID;

	logic [NP-1:0] req_m;
	logic [NP-1:0] grant_q;
	logic          locked_q;
	port_e         last_win_q;
	port_e         win_idx;
	logic          win_found;
	logic          release_pkt;

	// an input never targets its own side.
	assign req_m = req_i & ~OWN_BIT;

	// search upward from one past the last winner, wrapping at NP.
	always_comb begin
		int idx;
		win_found = 1'b0;
		win_idx   = last_win_q;
		for (int k = 1; k <= NP; k++) begin
			idx = (int'(last_win_q) + k) % NP;
			if (!win_found && req_m[idx]) begin
				win_found = 1'b1;
				win_idx   = port_e'(idx);
			end
		end
	end

	assign release_pkt = locked_q && |(grant_q & last_i);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			grant_q    <= '0;
			locked_q   <= 1'b0;
			last_win_q <= PORT_L; // first search starts at north.
		end else if (release_pkt) begin
			grant_q  <= '0; // no regrant on the release edge.
			locked_q <= 1'b0;
		end else if (!locked_q && win_found) begin
			grant_q    <= NP'(1) << win_idx;
			locked_q   <= 1'b1;
			last_win_q <= win_idx;
		end
	end

	assign grant_o  = grant_q;
	assign locked_o = locked_q;

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		$onehot0(grant_q)
	) else $error("output %0d granted several inputs", PORT_ID);

	// granted input stays busy until its last read.
	a_grant_held: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		locked_q |-> |(grant_q & req_m)
	) else $error("output %0d lost its requester mid packet", PORT_ID);

endmodule

`default_nettype wire

// ==== src/credit_counter.sv ====
//******************************
// credit counter
// free slots in the downstream buffer of one output.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

module credit_counter (
	input  logic clk,
	input  logic arst_n_i,
	input  logic consume_i,
	input  logic credit_i,
	output logic avail_o
);

	localparam int CNT_W = $clog2(`NOC_CREDITS + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`NOC_CREDITS);

	logic [CNT_W-1:0] cnt_q;

	// read and return in one cycle cancel out.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= CNT_MAX; // downstream starts empty.
		end else if (consume_i && !credit_i) begin
			cnt_q <= cnt_q - 1'b1;
		end else if (credit_i && !consume_i) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign avail_o = cnt_q != '0;

	a_no_overdraw: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		consume_i |-> (cnt_q != '0)
	) else $error("flit sent with no downstream credit");

	// upstream returned more than was sent.
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		cnt_q <= CNT_MAX
	) else $error("credit count above buffer depth");

endmodule

`default_nettype wire

// ==== src/router_arbiter.sv ====
//******************************
// router arbiter
// five input controllers, five output arbiters and five
// credit counters with the read and credit wiring between them.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

module router_arbiter (
	input  logic                                           clk,
	input  logic                                           arst_n_i,
	input  noc_arbiter_pkg::router_addr_t                  router_addr_i,
	input  logic [`NOC_PORTS-1:0]                          ib_valid_i,
	input  noc_arbiter_pkg::router_addr_t [`NOC_PORTS-1:0] hdr_addr_i,
	input  logic [`NOC_PORTS-1:0]                          credit_i,
	output logic [`NOC_PORTS-1:0]                          rd_o,
	output noc_arbiter_pkg::port_e [`NOC_PORTS-1:0]        route_o,
	output logic [`NOC_PORTS-1:0]                          out_valid_o,
	output noc_arbiter_pkg::port_e [`NOC_PORTS-1:0]        out_sel_o
);

	import noc_arbiter_pkg::*;

	localparam int NP = `NOC_PORTS;

	port_e         hop [NP];
	logic [NP-1:0] busy;
	logic [NP-1:0] last;
	logic [NP-1:0] rd;
	logic [NP-1:0] req_in [NP];  // per input, over outputs.
	logic [NP-1:0] req_out [NP]; // per output, over inputs.
	logic [NP-1:0] grant [NP];   // per output, over inputs.
	logic [NP-1:0] gnt_in [NP];  // per input, over outputs.
	logic [NP-1:0] locked;
	logic [NP-1:0] avail;

	for (genvar p = 0; p < NP; p++) begin : g_input
		input_port_ctrl #(
			.PORT_ID (port_e'(p))
		) input_port_ctrl_inst (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.ib_valid_i    (ib_valid_i[p]),
			.hdr_addr_i    (hdr_addr_i[p]),
			.router_addr_i (router_addr_i),
			.rd_i          (rd[p]),
			.hop_o         (hop[p]),
			.busy_o        (busy[p]),
			.req_o         (req_in[p]),
			.last_o        (last[p])
		);

		// pop when granted, flit present and the hop has room.
		assign rd[p] = busy[p] & ib_valid_i[p] & (|gnt_in[p]) & avail[hop[p]];

		assign rd_o[p]    = rd[p]; // also the credit back upstream.
		assign route_o[p] = hop[p];
	end

	// transpose between input and output views.
	for (genvar o = 0; o < NP; o++) begin : g_regroup
		for (genvar p = 0; p < NP; p++) begin : g_bit
			assign req_out[o][p] = req_in[p][o];
			assign gnt_in[p][o]  = grant[o][p];
		end
	end

	for (genvar o = 0; o < NP; o++) begin : g_output
		rr_arbiter #(
			.PORT_ID (port_e'(o))
		) rr_arbiter_inst (
			.clk      (clk),
			.arst_n_i (arst_n_i),
			.req_i    (req_out[o]),
			.last_i   (last),
			.grant_o  (grant[o]),
			.locked_o (locked[o])
		);

		assign out_valid_o[o] = locked[o] & (|(grant[o] & rd));

		credit_counter credit_counter_inst (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.consume_i (out_valid_o[o]),
			.credit_i  (credit_i[o]),
			.avail_o   (avail[o])
		);
	end

	// crossbar select from the one-hot grant, north when idle.
	always_comb begin
		for (int o = 0; o < NP; o++) begin
			out_sel_o[o] = PORT_N;
			for (int p = 0; p < NP; p++) begin
				if (grant[o][p]) begin
					out_sel_o[o] = port_e'(p);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_router_arbiter.sv ====
//******************************
// router arbiter testbench
// random packets on all five inputs against a cycle model
// of yx routing, round-robin lock and credits.
//******************************

`default_nettype none

`include "noc_arbiter_defines.svh"

module tb_router_arbiter;

	import noc_arbiter_pkg::*;

	localparam int NP         = `NOC_PORTS;
	localparam int PKTS       = 8; // per input.
	localparam int TOTAL_PKTS = NP * PKTS;
	localparam int FLITS      = `NOC_PKT_FLITS;
	localparam int CREDITS    = `NOC_CREDITS;
	localparam int MAX_CYCLES = TOTAL_PKTS * FLITS * 25; // 160 flits, heavily throttled.

	logic                  clk;
	logic                  arst_n;
	router_addr_t          router_addr;
	logic [NP-1:0]         ib_valid;
	router_addr_t [NP-1:0] hdr_addr;
	logic [NP-1:0]         credit;
	logic [NP-1:0]         rd;
	port_e [NP-1:0]        route;
	logic [NP-1:0]         out_valid;
	port_e [NP-1:0]        out_sel;

	integer        seed = 11500;
	int            cycle_cnt = 0;
	int            total_done;
	router_addr_t  dest [NP][PKTS];
	logic [NP-1:0] m_busy;   // input state.
	int            m_hop [NP];
	int            m_cnt [NP];
	int            m_pkt_idx [NP];
	logic [NP-1:0] m_locked; // output state.
	int            m_win [NP];
	int            m_last_win [NP];
	int            m_cred [NP];
	logic [NP-1:0] m_rd;
	logic [NP-1:0] m_last;
	logic [NP-1:0] m_ov;
	int            pkt_sel [NP];
	int            pkt_reads [NP];

	router_arbiter router_arbiter_inst (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.router_addr_i (router_addr),
		.ib_valid_i    (ib_valid),
		.hdr_addr_i    (hdr_addr),
		.credit_i      (credit),
		.rd_o          (rd),
		.route_o       (route),
		.out_valid_o   (out_valid),
		.out_sel_o     (out_sel)
	);

	always #5 clk = ~clk;

	// rows first, then columns.
	function automatic int compute_hop(input router_addr_t dst, input router_addr_t here);
		if (dst.y < here.y) begin
			return PORT_N;
		end else if (dst.y > here.y) begin
			return PORT_S;
		end else if (dst.x < here.x) begin
			return PORT_W;
		end else if (dst.x > here.x) begin
			return PORT_E;
		end
		return PORT_L;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// 4x4 mesh, no destination that turns back to the input side.
	task automatic make_packets();
		logic [31:0] rnd;
		router_addr_t a;
		for (int p = 0; p < NP; p++) begin
			for (int k = 0; k < PKTS; k++) begin
				do begin
					rnd = $random(seed);
					a = {2'b00, rnd[3:2], 2'b00, rnd[1:0]};
				end while (compute_hop(a, router_addr) == p);
				dest[p][k] = a;
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] rnd;
		for (int p = 0; p < NP; p++) begin
			rnd = $random(seed);
			if (m_pkt_idx[p] < PKTS) begin
				hdr_addr[p] = dest[p][m_pkt_idx[p]]; // next head flit.
			end else begin
				hdr_addr[p] = '0;
			end
			ib_valid[p] = (m_busy[p] || m_pkt_idx[p] < PKTS) && rnd[0];
			credit[p]   = (m_cred[p] < CREDITS) && rnd[1]; // only what is outstanding.
		end
	endtask

	task automatic model_outputs();
		int o;
		m_rd   = '0;
		m_last = '0;
		m_ov   = '0;
		for (int p = 0; p < NP; p++) begin
			o = m_hop[p];
			if (m_busy[p] && ib_valid[p] && m_locked[o] && m_win[o] == p && m_cred[o] > 0) begin
				m_rd[p]   = 1'b1;
				m_ov[o]   = 1'b1;
				m_last[p] = (m_cnt[p] == FLITS - 1);
			end
		end
	endtask

	task automatic compare_outputs();
		int exp_sel;
		for (int o = 0; o < NP; o++) begin
			if (m_cred[o] == 0) begin
				check_value($sformatf("out_valid_o[%0d] at zero credit", o), out_valid[o], 0);
			end
			// select frozen until the packet has drained.
			if (pkt_reads[o] != 0) begin
				check_value($sformatf("out_sel_o[%0d] mid packet", o), out_sel[o], pkt_sel[o]);
			end
		end
		check_value("rd_o", rd, m_rd);
		check_value("out_valid_o", out_valid, m_ov);
		for (int p = 0; p < NP; p++) begin
			if (m_busy[p]) begin
				check_value($sformatf("route_o[%0d]", p), route[p], m_hop[p]);
			end
		end
		for (int o = 0; o < NP; o++) begin
			exp_sel = m_locked[o] ? m_win[o] : PORT_N; // round-robin winner.
			check_value($sformatf("out_sel_o[%0d]", o), out_sel[o], exp_sel);
			if (m_ov[o]) begin
				if (pkt_reads[o] == 0) begin
					pkt_sel[o] = out_sel[o];
				end
				pkt_reads[o] = (pkt_reads[o] + 1) % FLITS;
			end
		end
	endtask

	task automatic advance_model();
		int idx;
		logic found;
		// arbiters see the requests from before this edge.
		for (int o = 0; o < NP; o++) begin
			if (m_locked[o]) begin
				if (m_last[m_win[o]]) begin
					m_locked[o] = 1'b0;
				end
			end else begin
				found = 1'b0;
				for (int k = 1; k <= NP; k++) begin
					idx = (m_last_win[o] + k) % NP;
					if (!found && idx != o && m_busy[idx] && m_hop[idx] == o) begin
						found         = 1'b1;
						m_win[o]      = idx;
						m_last_win[o] = idx;
						m_locked[o]   = 1'b1;
					end
				end
			end
			if (m_ov[o] && !credit[o]) begin
				m_cred[o]--;
			end else if (credit[o] && !m_ov[o]) begin
				m_cred[o]++;
			end
		end
		for (int p = 0; p < NP; p++) begin
			if (!m_busy[p] && ib_valid[p]) begin
				m_busy[p] = 1'b1;
				m_hop[p]  = compute_hop(hdr_addr[p], router_addr);
				m_cnt[p]  = 0;
				m_pkt_idx[p]++;
			end else if (m_rd[p]) begin
				if (m_last[p]) begin
					m_busy[p] = 1'b0;
					m_cnt[p]  = 0;
					total_done++;
				end else begin
					m_cnt[p]++;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			stop_with_failure($sformatf("timeout, only %0d of %0d packets done after %0d cycles",
				total_done, TOTAL_PKTS, cycle_cnt));
		end
	end

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		router_addr = 8'h11;
		ib_valid    = '0;
		hdr_addr    = '0;
		credit      = '0;
		total_done  = 0;
		m_busy      = '0;
		m_locked    = '0;
		for (int i = 0; i < NP; i++) begin
			m_hop[i]      = 0;
			m_cnt[i]      = 0;
			m_pkt_idx[i]  = 0;
			m_win[i]      = 0;
			m_last_win[i] = PORT_L; // first search starts at north.
			m_cred[i]     = CREDITS;
			pkt_sel[i]    = 0;
			pkt_reads[i]  = 0;
		end
		make_packets();
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_value("rd_o", rd, 0);
		check_value("out_valid_o", out_valid, 0);
		@(posedge clk);
		#1;
		arst_n = 1'b1;
		while (total_done < TOTAL_PKTS) begin
			drive_inputs();
			@(negedge clk);
			model_outputs();
			compare_outputs();
			advance_model();
			@(posedge clk);
			#1;
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== noc_arbiter.f ====
+incdir+src
src/noc_arbiter_pkg.sv
src/yx_route.sv
src/input_port_ctrl.sv
src/rr_arbiter.sv
src/credit_counter.sv
src/router_arbiter.sv
testbench/tb_router_arbiter.sv

// ==== Bender.yml ====
package:
  name: noc_arbiter

export_include_dirs:
  - src

sources:
  - src/noc_arbiter_pkg.sv
  - src/yx_route.sv
  - src/input_port_ctrl.sv
  - src/rr_arbiter.sv
  - src/credit_counter.sv
  - src/router_arbiter.sv
  - target: test
    files:
      - testbench/tb_router_arbiter.sv
